//--- hdl/cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    localparam int xlen        = 64;
    localparam int inst_w      = 32;
    localparam int reg_index_w = 5;
    localparam int reg_count   = 32;
    localparam int shamt_w     = 6;

    // first fetch address after reset
    localparam logic [xlen-1:0] pc_start = 64'h0000_0000_8000_0000;

    // custom opcode that stops the core, x10 low byte is the trap code
    localparam logic [6:0] halt_opcode = 7'h6b;

    // major opcodes kept in this core
    typedef enum logic [6:0] {
        op_imm  = 7'h13,
        op_reg  = 7'h33,
        op_lui  = 7'h37,
        op_halt = halt_opcode
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        shift_sll,
        shift_srl,
        shift_sra
    } shift_op_e;

    // write-back source
    typedef enum logic [1:0] {
        res_alu,
        res_shift,
        res_imm
    } result_sel_e;

endpackage

//--- hdl/inst_fetch.sv
module inst_fetch (
    input  logic                       inst_selfdefine,
    input  logic                       reset,
    input  logic                       if_ready,
    input  logic [cpu_pkg::inst_w-1:0] if_data_read,
    input  logic                       halt_taken,
    output logic                       if_valid,
    output logic [cpu_pkg::xlen-1:0]   if_addr,
    output logic [cpu_pkg::inst_w-1:0] inst,
    output logic                       inst_valid,
    output logic [cpu_pkg::xlen-1:0]   pc
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_halt
    } fetch_state_e;

    fetch_state_e    state;
    logic [xlen-1:0] pc_q;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= st_fetch;
            pc_q  <= pc_start;
        end else begin
            case (state)
                st_fetch: begin
                    if (if_ready) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    pc_q  <= pc_q + xlen'(4);
                    // halt parks the fetch side until reset
                    state <= halt_taken ? st_halt : st_fetch;
                end
                default: begin
                    state <= st_halt;
                end
            endcase
        end
    end

    // capture on the handshake edge
    always_ff @(posedge inst_selfdefine) begin
        if (if_valid && if_ready) begin
            inst <= if_data_read;
        end
    end

    assign if_valid   = state == st_fetch;
    assign inst_valid = state == st_exec;
    assign if_addr    = pc_q;
    assign pc         = pc_q;

endmodule

//--- hdl/inst_decode.sv
module inst_decode (
    input  logic [cpu_pkg::inst_w-1:0]      inst,
    input  logic                            inst_valid,
    output logic [cpu_pkg::reg_index_w-1:0] rs1_index,
    output logic [cpu_pkg::reg_index_w-1:0] rs2_index,
    output logic [cpu_pkg::reg_index_w-1:0] rd_index,
    output logic                            rd_en,
    output logic                            src_imm,
    output logic [cpu_pkg::xlen-1:0]        imm_data,
    output cpu_pkg::alu_op_e                alu_op,
    output cpu_pkg::shift_op_e              shift_op,
    output cpu_pkg::result_sel_e            result_sel,
    output logic                            halt
);
    import cpu_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode    = opcode_e'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign rs1_index = inst[19:15];
    assign rs2_index = inst[24:20];
    assign rd_index  = inst[11:7];

    always_comb begin
        legal      = 1'b0;
        src_imm    = 1'b0;
        imm_data   = {{(xlen-12){inst[31]}}, inst[31:20]};
        alu_op     = alu_add;
        shift_op   = shift_sll;
        result_sel = res_alu;

        // funct3 picks the operation for both OP and OP-IMM
        case (funct3)
            3'b001: result_sel = res_shift;
            3'b010: alu_op = alu_slt;
            3'b011: alu_op = alu_sltu;
            3'b100: alu_op = alu_xor;
            3'b101: begin
                result_sel = res_shift;
                shift_op   = inst[30] ? shift_sra : shift_srl;
            end
            3'b110: alu_op = alu_or;
            3'b111: alu_op = alu_and;
            default: alu_op = alu_add;
        endcase

        case (opcode)
            op_imm: begin
                src_imm = 1'b1;
                // rv64 shamt is 6 bits, upper bits must be clean
                if (funct3 == 3'b001) begin
                    legal = inst[31:26] == 6'b000000;
                end else if (funct3 == 3'b101) begin
                    legal = inst[31:26] == 6'b000000 || inst[31:26] == 6'b010000;
                end else begin
                    legal = 1'b1;
                end
            end
            op_reg: begin
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    legal = funct7 == 7'h00 || funct7 == 7'h20;
                end else begin
                    legal = funct7 == 7'h00;
                end
                if (funct3 == 3'b000 && inst[30]) begin
                    alu_op = alu_sub;
                end
            end
            op_lui: begin
                legal      = 1'b1;
                result_sel = res_imm;
                imm_data   = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    assign rd_en = inst_valid & legal & (rd_index != '0);
    assign halt  = inst_valid & (opcode == op_halt);

endmodule

//--- hdl/operand_regfile.sv
module operand_regfile (
    input  logic                            inst_selfdefine,
    input  logic                            reset,
    input  logic [cpu_pkg::reg_index_w-1:0] rs1_index,
    input  logic [cpu_pkg::reg_index_w-1:0] rs2_index,
    input  logic                            src_imm,
    input  logic [cpu_pkg::xlen-1:0]        imm_data,
    input  logic                            wr_en,
    input  logic [cpu_pkg::reg_index_w-1:0] wr_index,
    input  logic [cpu_pkg::xlen-1:0]        wr_data,
    output logic [cpu_pkg::xlen-1:0]        op_a,
    output logic [cpu_pkg::xlen-1:0]        op_b,
    output logic [cpu_pkg::xlen-1:0]        x10_data
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [reg_count];
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_index != '0) begin
            regs[wr_index] <= wr_data;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];

    assign op_a = rs1_data;
    assign op_b = src_imm ? imm_data : rs2_data;

    // a0, source of the trap code
    assign x10_data = regs[10];

endmodule

//--- hdl/alu_unit.sv
module alu_unit (
    input  logic [cpu_pkg::xlen-1:0] op_a,
    input  logic [cpu_pkg::xlen-1:0] op_b,
    input  cpu_pkg::alu_op_e         alu_op,
    output logic [cpu_pkg::xlen-1:0] alu_res
);
    import cpu_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_res = op_a + op_b;
            end
            alu_sub: begin
                alu_res = op_a - op_b;
            end
            alu_and: begin
                alu_res = op_a & op_b;
            end
            alu_or: begin
                alu_res = op_a | op_b;
            end
            alu_xor: begin
                alu_res = op_a ^ op_b;
            end
            alu_slt: begin
                alu_res = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                alu_res = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

//--- hdl/shift_unit.sv
module shift_unit (
    input  logic [cpu_pkg::xlen-1:0] op_a,
    input  logic [cpu_pkg::xlen-1:0] op_b,
    input  cpu_pkg::shift_op_e       shift_op,
    output logic [cpu_pkg::xlen-1:0] shift_res
);
    import cpu_pkg::*;

    logic [shamt_w-1:0] shamt;

    // only the low bits count, for both rs2 and the immediate
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (shift_op)
            shift_sll: begin
                shift_res = op_a << shamt;
            end
            shift_srl: begin
                shift_res = op_a >> shamt;
            end
            shift_sra: begin
                shift_res = $unsigned($signed(op_a) >>> shamt);
            end
            default: begin
                shift_res = '0;
            end
        endcase
    end

endmodule

//--- hdl/commit_stage.sv
module commit_stage (
    input  logic                            inst_selfdefine,
    input  logic                            reset,
    input  logic                            inst_valid,
    input  logic [cpu_pkg::xlen-1:0]        pc,
    input  logic [cpu_pkg::reg_index_w-1:0] rd_index,
    input  logic                            rd_en,
    input  cpu_pkg::result_sel_e            result_sel,
    input  logic [cpu_pkg::xlen-1:0]        alu_res,
    input  logic [cpu_pkg::xlen-1:0]        shift_res,
    input  logic [cpu_pkg::xlen-1:0]        imm_data,
    input  logic                            halt,
    input  logic [cpu_pkg::xlen-1:0]        x10_data,
    output logic                            wr_en,
    output logic [cpu_pkg::reg_index_w-1:0] wr_index,
    output logic [cpu_pkg::xlen-1:0]        wr_data,
    output logic                            halt_taken,
    output logic                            cmt_valid,
    output logic [cpu_pkg::xlen-1:0]        cmt_pc,
    output logic [cpu_pkg::reg_index_w-1:0] cmt_wdest,
    output logic                            cmt_wen,
    output logic [cpu_pkg::xlen-1:0]        cmt_wdata,
    output logic                            halted,
    output logic [7:0]                      trap_code
);
    import cpu_pkg::*;

    always_comb begin
        case (result_sel)
            res_shift: wr_data = shift_res;
            res_imm:   wr_data = imm_data;
            default:   wr_data = alu_res;
        endcase
    end

    // rd_en already excludes x0 and illegal words
    assign wr_en      = inst_valid & rd_en;
    assign wr_index   = rd_index;
    assign halt_taken = inst_valid & halt;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            cmt_valid <= 1'b0;
            halted    <= 1'b0;
            trap_code <= '0;
        end else begin
            cmt_valid <= inst_valid;
            if (halt_taken) begin
                halted    <= 1'b1;
                trap_code <= x10_data[7:0];
            end
        end
    end

    // commit record, one cycle behind execute
    always_ff @(posedge inst_selfdefine) begin
        if (inst_valid) begin
            cmt_pc    <= pc;
            cmt_wdest <= rd_index;
            cmt_wen   <= wr_en;
            cmt_wdata <= wr_data;
        end
    end

endmodule

//--- hdl/cpu.sv
module cpu (
    input  logic                            inst_selfdefine,
    input  logic                            reset,
    input  logic                            if_ready,
    input  logic [cpu_pkg::inst_w-1:0]      if_data_read,
    output logic                            if_valid,
    output logic [cpu_pkg::xlen-1:0]        if_addr,
    output logic                            cmt_valid,
    output logic [cpu_pkg::xlen-1:0]        cmt_pc,
    output logic [cpu_pkg::reg_index_w-1:0] cmt_wdest,
    output logic                            cmt_wen,
    output logic [cpu_pkg::xlen-1:0]        cmt_wdata,
    output logic                            halted,
    output logic [7:0]                      trap_code
);

    logic [cpu_pkg::inst_w-1:0]      inst;
    logic                            inst_valid;
    logic [cpu_pkg::xlen-1:0]        pc;
    logic                            halt_taken;
    logic [cpu_pkg::reg_index_w-1:0] rs1_index;
    logic [cpu_pkg::reg_index_w-1:0] rs2_index;
    logic [cpu_pkg::reg_index_w-1:0] rd_index;
    logic                            rd_en;
    logic                            src_imm;
    logic [cpu_pkg::xlen-1:0]        imm_data;
    cpu_pkg::alu_op_e                alu_op;
    cpu_pkg::shift_op_e              shift_op;
    cpu_pkg::result_sel_e            result_sel;
    logic                            halt;
    logic [cpu_pkg::xlen-1:0]        op_a;
    logic [cpu_pkg::xlen-1:0]        op_b;
    logic [cpu_pkg::xlen-1:0]        x10_data;
    logic [cpu_pkg::xlen-1:0]        alu_res;
    logic [cpu_pkg::xlen-1:0]        shift_res;
    logic                            wr_en;
    logic [cpu_pkg::reg_index_w-1:0] wr_index;
    logic [cpu_pkg::xlen-1:0]        wr_data;

    inst_fetch i_inst_fetch (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .if_ready(if_ready), .if_data_read(if_data_read), .halt_taken(halt_taken),
        .if_valid(if_valid), .if_addr(if_addr),
        .inst(inst), .inst_valid(inst_valid), .pc(pc)
    );

    inst_decode i_inst_decode (
        .inst(inst), .inst_valid(inst_valid),
        .rs1_index(rs1_index), .rs2_index(rs2_index), .rd_index(rd_index), .rd_en(rd_en),
        .src_imm(src_imm), .imm_data(imm_data), .alu_op(alu_op), .shift_op(shift_op),
        .result_sel(result_sel), .halt(halt)
    );

    operand_regfile i_operand_regfile (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .rs1_index(rs1_index), .rs2_index(rs2_index), .src_imm(src_imm), .imm_data(imm_data),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .op_a(op_a), .op_b(op_b), .x10_data(x10_data)
    );

    alu_unit i_alu_unit (
        .op_a(op_a), .op_b(op_b), .alu_op(alu_op), .alu_res(alu_res)
    );

    shift_unit i_shift_unit (
        .op_a(op_a), .op_b(op_b), .shift_op(shift_op), .shift_res(shift_res)
    );

    commit_stage i_commit_stage (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .inst_valid(inst_valid), .pc(pc), .rd_index(rd_index), .rd_en(rd_en),
        .result_sel(result_sel), .alu_res(alu_res), .shift_res(shift_res),
        .imm_data(imm_data), .halt(halt), .x10_data(x10_data),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .halt_taken(halt_taken),
        .cmt_valid(cmt_valid), .cmt_pc(cmt_pc), .cmt_wdest(cmt_wdest), .cmt_wen(cmt_wen),
        .cmt_wdata(cmt_wdata), .halted(halted), .trap_code(trap_code)
    );

endmodule

//--- tests/fetch_responder.sv
module fetch_responder (
    input  logic                       inst_selfdefine,
    input  logic                       if_valid,
    input  logic [cpu_pkg::xlen-1:0]   if_addr,
    output logic                       if_ready,
    output logic [cpu_pkg::inst_w-1:0] if_data_read
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int mem_depth = 512;

    logic [inst_w-1:0] mem [mem_depth];
    logic [xlen-1:0]   word_index;
    int                wait_left;

    assign word_index = (if_addr - pc_start) >> 2;

    initial begin
        if_ready     = 1'b0;
        if_data_read = '0;
        wait_left    = -1;
    end

    // random 0..3 cycle stall per request
    always @(negedge inst_selfdefine) begin
        if (!if_valid) begin
            if_ready  = 1'b0;
            wait_left = -1;
        end else if (!if_ready) begin
            if (wait_left < 0) begin
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                if_ready     = 1'b1;
                if_data_read = (word_index < xlen'(mem_depth)) ? mem[word_index[8:0]] : '0;
            end else begin
                wait_left--;
            end
        end
    end

endmodule

//--- tests/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int clk_period = 100;
    localparam int mem_depth  = 512;
    localparam int prog_len   = 308;
    localparam int max_insts  = 310;

    logic                   inst_selfdefine = 1'b0;
    logic                   reset = 1'b1;
    logic                   if_ready;
    logic [inst_w-1:0]      if_data_read;
    logic                   if_valid;
    logic [xlen-1:0]        if_addr;
    logic                   cmt_valid;
    logic [xlen-1:0]        cmt_pc;
    logic [reg_index_w-1:0] cmt_wdest;
    logic                   cmt_wen;
    logic [xlen-1:0]        cmt_wdata;
    logic                   halted;
    logic [7:0]             trap_code;

    logic [xlen-1:0]        model_regs [reg_count];
    int                     commit_count = 0;
    int                     fetch_count = 0;
    logic [xlen-1:0]        exp_pc = '0;
    logic [xlen-1:0]        exp_wdata = '0;
    logic [reg_index_w-1:0] exp_wdest = '0;
    logic                   exp_wen = 1'b0;
    logic                   exp_shift = 1'b0;
    logic                   exp_halt = 1'b0;
    logic [7:0]             exp_trap = '0;

    cpu i_cpu (.*);
    fetch_responder i_fetch_responder (.*);

    always #(clk_period / 2) inst_selfdefine = ~inst_selfdefine;

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAIL %s expected %0h actual %0h", test, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    function automatic logic [31:0] random_inst(input logic force_x0);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [5:0]  shamt;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          pick;
        rd    = force_x0 ? 5'd0 : 5'($urandom);
        f3    = 3'($urandom);
        shamt = 6'($urandom);
        pick  = $urandom_range(20, 0);
        if (pick < 9) begin
            imm = 12'($urandom);
            if (f3 == 3'b001) begin
                imm = {6'b000000, shamt};
            end else if (f3 == 3'b101) begin
                imm = {($urandom_range(1, 0) == 1 ? 6'b010000 : 6'b000000), shamt};
            end
            return {imm, 5'($urandom), f3, rd, 7'h13};
        end else if (pick < 19) begin
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
            return {f7, 5'($urandom), 5'($urandom), f3, rd, 7'h33};
        end
        return {20'($urandom), rd, 7'h37};
    endfunction

    // reference model, one step per commit pulse
    always @(negedge inst_selfdefine) begin
        logic [31:0]     word;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic            legal;
        if (cmt_valid) begin
            word = i_fetch_responder.mem[commit_count[8:0]];
            opc  = word[6:0];
            f3   = word[14:12];
            a    = model_regs[word[19:15]];
            b    = (opc == 7'h13) ? {{52{word[31]}}, word[31:20]} : model_regs[word[24:20]];
            case (f3)
                3'b000: res = (opc == 7'h33 && word[30]) ? a - b : a + b;
                3'b001: res = a << b[5:0];
                3'b010: res = xlen'($signed(a) < $signed(b));
                3'b011: res = xlen'(a < b);
                3'b100: res = a ^ b;
                3'b101: begin
                    if (word[30]) res = $signed(a) >>> b[5:0];
                    else res = a >> b[5:0];
                end
                3'b110: res = a | b;
                default: res = a & b;
            endcase
            if (opc == 7'h37) begin
                res = {{32{word[31]}}, word[31:12], 12'b0};
            end
            // shift encodings keep the upper immediate bits clean
            legal = opc == 7'h37
                || (opc == 7'h13 && ((f3 != 3'b001 && f3 != 3'b101)
                    || ({word[31], word[29:26]} == 5'b0 && (!word[30] || f3 == 3'b101))))
                || (opc == 7'h33 && {word[31], word[29:25]} == 6'b0
                    && (!word[30] || f3 == 3'b000 || f3 == 3'b101));
            exp_pc    = pc_start + xlen'(commit_count) * 64'd4;
            exp_wen   = legal && word[11:7] != 5'd0;
            exp_wdest = word[11:7];
            exp_wdata = res;
            exp_shift = opc != 7'h37 && (f3 == 3'b001 || f3 == 3'b101);
            exp_halt  = opc == halt_opcode;
            exp_trap  = model_regs[10][7:0];
            if (exp_wen) begin
                model_regs[word[11:7]] = res;
            end
            commit_count++;
        end
    end

    always @(posedge inst_selfdefine) begin
        if (!reset && if_valid && if_ready) begin
            fetch_count <= fetch_count + 1;
        end
    end

    reset_state: assert property (@(posedge inst_selfdefine) reset |=> !cmt_valid && !halted)
        else report_failure("reset_state: commit or halt active right after reset");
    reset_fetch: assert property (@(posedge inst_selfdefine) $fell(reset) |-> if_valid)
        else report_failure("reset_state: no fetch request after reset");
    reset_addr: assert property (@(posedge inst_selfdefine) $fell(reset) |-> if_addr == pc_start)
        else report_mismatch("reset_state", pc_start, if_addr);
    commit_pc: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid |-> cmt_pc == exp_pc)
        else report_mismatch("commit_pc", exp_pc, cmt_pc);
    alu_results: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid && exp_wen && !exp_shift |-> cmt_wdata == exp_wdata)
        else report_mismatch("alu_results", exp_wdata, cmt_wdata);
    shift_results: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid && exp_wen && exp_shift |-> cmt_wdata == exp_wdata)
        else report_mismatch("shift_results", exp_wdata, cmt_wdata);
    commit_dest: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid && exp_wen |-> cmt_wdest == exp_wdest)
        else report_mismatch("commit_dest", exp_wdest, cmt_wdest);
    no_write_cases: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid |-> cmt_wen == exp_wen)
        else report_mismatch("no_write_cases", exp_wen, cmt_wen);
    fetch_stable: assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && !if_ready |=> $stable(if_addr))
        else report_failure("fetch_backpressure: if_addr moved while if_ready was low");
    fetch_backpressure: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid |-> fetch_count == commit_count)
        else report_mismatch("fetch_backpressure", fetch_count, commit_count);
    halt_flag: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid && exp_halt |-> halted)
        else report_failure("halt_trap: halted not set with the halt commit");
    halt_trap: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cmt_valid && exp_halt |-> trap_code == exp_trap)
        else report_mismatch("halt_trap", exp_trap, trap_code);
    halt_quiet: assert property (@(posedge inst_selfdefine) disable iff (reset)
        halted |-> !if_valid)
        else report_failure("halt_trap: fetch request after halt");

    initial begin
        #(max_insts * 6 * clk_period);
        report_failure("watchdog expired before the core halted");
    end

    initial begin
        void'($urandom(89));
        for (int r = 0; r < reg_count; r++) begin
            model_regs[r] = '0;
        end
        // program, a few illegal words, halt, then opcode-zero filler
        for (int i = 0; i < mem_depth; i++) begin
            if (i < prog_len - 1 && i % 88 == 20) begin
                i_fetch_responder.mem[i] = {7'h01, 5'($urandom), 5'($urandom), 3'b000, 5'd5, 7'h33};
            end else if (i < prog_len - 1 && i % 44 == 20) begin
                i_fetch_responder.mem[i] = {25'($urandom), 7'h03};
            end else if (i < prog_len - 1) begin
                i_fetch_responder.mem[i] = random_inst(i % 30 == 7);
            end else if (i == prog_len - 1) begin
                i_fetch_responder.mem[i] = {25'd0, halt_opcode};
            end else begin
                i_fetch_responder.mem[i] = {25'(i), 7'h00};
            end
        end
        repeat (10) @(negedge inst_selfdefine);
        reset = 1'b0;
        wait (halted === 1'b1);
        repeat (8) @(negedge inst_selfdefine);
        if (commit_count != prog_len || fetch_count != prog_len) begin
            report_failure("run ended before every instruction was committed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- cpu.f
hdl/cpu_pkg.sv
hdl/inst_fetch.sv
hdl/inst_decode.sv
hdl/operand_regfile.sv
hdl/alu_unit.sv
hdl/shift_unit.sv
hdl/commit_stage.sv
hdl/cpu.sv
tests/fetch_responder.sv
tests/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
